//--- accel_defs.svh
`ifndef ACCEL_DEFS_SVH
`define ACCEL_DEFS_SVH

// Stream and memory widths
`define ACC_HALF_W        16
`define ACC_WORD_W        32
`define ACC_LINE_WORDS    8
`define ACC_LINE_HALVES   16

// Bank depths
`define ACC_INSTR_DEPTH   512
`define ACC_DATA_DEPTH    256

`define ACC_FIFO_DEPTH    4

// Wishbone word address map
`define ACC_WB_ADR_W      12
`define ACC_WB_BANK_BIT   11
`define ACC_WB_INSTR_MSB  8
`define ACC_WB_LINE_MSB   10
`define ACC_WB_LINE_LSB   3
`define ACC_WB_WORD_MSB   2

`endif

//--- accel_pkg.sv
`include "accel_defs.svh"

package accel_pkg;

    typedef logic [`ACC_HALF_W-1:0] half_t;
    typedef logic [`ACC_WORD_W-1:0] word_t;
    typedef logic [$clog2(`ACC_INSTR_DEPTH)-1:0] instr_addr_t;
    typedef logic [$clog2(`ACC_DATA_DEPTH)-1:0] line_addr_t;

    // One data line, seen as words by the bus and as halfwords by the streams
    typedef union packed {
        word_t [`ACC_LINE_WORDS-1:0]  words;
        half_t [`ACC_LINE_HALVES-1:0] halves;
    } data_line_u;

    typedef enum logic [1:0] {
        load_instr = 2'd0,
        load_data  = 2'd1,
        drain      = 2'd2,
        reserved   = 2'd3
    } cmd_kind_e;

    typedef struct packed {
        cmd_kind_e  kind;
        logic [5:0] rsvd;
        logic [7:0] count;
    } cmd_t;

    typedef struct packed {
        logic                     cyc;
        logic                     stb;
        logic                     we;
        logic [`ACC_WB_ADR_W-1:0] adr;
        word_t                    dat;
    } wb_req_t;

    typedef struct packed {
        logic        valid;
        logic        data_bank;
        instr_addr_t addr;
        data_line_u  line;
    } load_wr_t;

    typedef struct packed {
        logic                               valid;
        logic                               we;
        logic                               data_bank;
        instr_addr_t                        idx;
        logic [$clog2(`ACC_LINE_WORDS)-1:0] word_sel;
        word_t                              data;
    } dbg_req_t;

    typedef struct packed {
        logic       valid;
        line_addr_t start;
        logic [7:0] count;
    } drain_job_t;

endpackage

//--- stream_fifo.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module stream_fifo (
    input  logic             clk,
    input  logic             rst_n_i,
    input  accel_pkg::half_t din_i,
    input  logic             push_i,
    output logic             full_n_o,
    output accel_pkg::half_t dout_o,
    input  logic             pop_i,
    output logic             empty_n_o
);
    import accel_pkg::*;

    localparam int unsigned PTR_W = $clog2(`ACC_FIFO_DEPTH);

    half_t            mem [`ACC_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full_n_o  = (count != (PTR_W + 1)'(`ACC_FIFO_DEPTH));
    assign empty_n_o = (count != '0);
    assign do_push   = push_i && full_n_o;
    assign do_pop    = pop_i && empty_n_o;
    assign dout_o    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din_i;
        end
    end

    // Pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- load_sequencer.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module load_sequencer (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  accel_pkg::half_t      in_data_i,
    input  logic                  in_empty_n_i,
    output logic                  in_pop_o,
    output accel_pkg::load_wr_t   load_wr_o,
    output accel_pkg::drain_job_t drain_job_o,
    input  logic                  drain_busy_i
);
    import accel_pkg::*;

    typedef enum logic [1:0] {
        st_cmd,
        st_addr,
        st_payload,
        st_wait_drain
    } state_e;

    state_e      state;
    cmd_t        cmd_q;
    logic [3:0]  half_idx;
    instr_addr_t item_addr;
    data_line_u  line_q;
    data_line_u  line_next;
    logic        last_half;

    // No halfwords are taken while a drain is running
    assign in_pop_o = in_empty_n_i && (state != st_wait_drain);

    always_comb begin
        line_next = line_q;
        line_next.halves[half_idx] = in_data_i;
    end

    assign last_half = (cmd_q.kind == load_data) ?
                       (half_idx == 4'(`ACC_LINE_HALVES - 1)) :
                       (half_idx == 4'(`ACC_WORD_W / `ACC_HALF_W - 1));

    // ---------------------------------------------------------
    // Command parser and item collector
    // ---------------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state             <= st_cmd;
            load_wr_o.valid   <= 1'b0;
            drain_job_o.valid <= 1'b0;
        end else begin
            load_wr_o.valid   <= 1'b0;
            drain_job_o.valid <= 1'b0;
            if (in_pop_o) begin
                case (state)
                    st_cmd: begin
                        cmd_q <= cmd_t'(in_data_i);
                        state <= st_addr;
                    end
                    st_addr: begin
                        case (cmd_q.kind)
                            drain: begin
                                drain_job_o <= '{valid: 1'b1,
                                                 start: in_data_i[7:0],
                                                 count: cmd_q.count};
                                state       <= st_wait_drain;
                            end
                            reserved: begin
                                state <= st_cmd;
                            end
                            default: begin
                                item_addr <= in_data_i[8:0];
                                half_idx  <= '0;
                                state     <= st_payload;
                            end
                        endcase
                    end
                    st_payload: begin
                        line_q   <= line_next;
                        half_idx <= half_idx + 1'b1;
                        if (last_half) begin
                            load_wr_o <= '{valid:     1'b1,
                                           data_bank: (cmd_q.kind == load_data),
                                           addr:      item_addr,
                                           line:      line_next};
                            item_addr <= item_addr + 1'b1;
                            half_idx  <= '0;
                            // Count holds the items left minus one
                            if (cmd_q.count == '0) begin
                                state <= st_cmd;
                            end else begin
                                cmd_q.count <= cmd_q.count - 1'b1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
            if (state == st_wait_drain && !drain_busy_i) begin
                state <= st_cmd;
            end
        end
    end

endmodule

//--- wb_debug_port.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module wb_debug_port (
    input  logic                clk,
    input  logic                rst_n_i,
    input  accel_pkg::wb_req_t  wb_i,
    output accel_pkg::word_t    wb_dat_o,
    output logic                wb_ack_o,
    output accel_pkg::dbg_req_t dbg_req_o,
    input  logic                dbg_grant_i,
    input  accel_pkg::word_t    dbg_rdata_i
);
    import accel_pkg::*;

    logic        bank_sel;
    instr_addr_t idx_dec;

    // Address decode
    assign bank_sel = wb_i.adr[`ACC_WB_BANK_BIT];
    assign idx_dec  = bank_sel ?
                      instr_addr_t'(wb_i.adr[`ACC_WB_LINE_MSB:`ACC_WB_LINE_LSB]) :
                      wb_i.adr[`ACC_WB_INSTR_MSB:0];

    // Read word is returned by the arbiter in the ack cycle
    assign wb_dat_o = dbg_rdata_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            dbg_req_o.valid <= 1'b0;
            wb_ack_o        <= 1'b0;
        end else begin
            wb_ack_o <= dbg_req_o.valid && dbg_grant_i;
            if (dbg_req_o.valid) begin
                if (dbg_grant_i) begin
                    dbg_req_o.valid <= 1'b0;
                end
            end else if (wb_i.cyc && wb_i.stb && !wb_ack_o) begin
                dbg_req_o <= '{valid:     1'b1,
                               we:        wb_i.we,
                               data_bank: bank_sel,
                               idx:       idx_dec,
                               word_sel:  wb_i.adr[`ACC_WB_WORD_MSB:0],
                               data:      wb_i.dat};
            end
        end
    end

endmodule

//--- bank_arbiter.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module bank_arbiter (
    input  logic                  clk,
    input  accel_pkg::load_wr_t   load_wr_i,
    input  accel_pkg::dbg_req_t   dbg_req_i,
    output logic                  dbg_grant_o,
    output accel_pkg::word_t      dbg_rdata_o,
    input  logic                  drain_rd_i,
    input  accel_pkg::line_addr_t drain_addr_i,
    output accel_pkg::data_line_u drain_line_o
);
    import accel_pkg::*;

    word_t                              instr_mem [`ACC_INSTR_DEPTH];
    data_line_u                         data_mem  [`ACC_DATA_DEPTH];

    line_addr_t                         dbg_line_addr;
    logic                               dbg_instr_wr;
    logic                               dbg_data_wr;
    logic [`ACC_LINE_WORDS-1:0]         word_mask;

    word_t                              instr_rd_q;
    data_line_u                         line_rd_q;
    logic                               rd_bank_q;
    logic [$clog2(`ACC_LINE_WORDS)-1:0] rd_word_q;

    // Loader writes always win
    assign dbg_grant_o   = dbg_req_i.valid && !load_wr_i.valid;
    assign dbg_line_addr = line_addr_t'(dbg_req_i.idx);
    assign dbg_instr_wr  = dbg_grant_o && dbg_req_i.we && !dbg_req_i.data_bank;
    assign dbg_data_wr   = dbg_grant_o && dbg_req_i.we && dbg_req_i.data_bank;
    assign word_mask     = dbg_data_wr ?
                           (`ACC_LINE_WORDS'(1) << dbg_req_i.word_sel) : '0;

    // ---------------------------------------------------------
    // Instruction bank
    // ---------------------------------------------------------

    always_ff @(posedge clk) begin
        if (load_wr_i.valid && !load_wr_i.data_bank) begin
            instr_mem[load_wr_i.addr] <= load_wr_i.line.words[0];
        end else if (dbg_instr_wr) begin
            instr_mem[dbg_req_i.idx] <= dbg_req_i.data;
        end
        if (dbg_grant_o) begin
            instr_rd_q <= instr_mem[dbg_req_i.idx];
        end
    end

    // ---------------------------------------------------------
    // Data bank, with a separate drain read port
    // ---------------------------------------------------------

    always_ff @(posedge clk) begin
        if (load_wr_i.valid && load_wr_i.data_bank) begin
            data_mem[line_addr_t'(load_wr_i.addr)] <= load_wr_i.line;
        end else begin
            for (int w = 0; w < `ACC_LINE_WORDS; w++) begin
                if (word_mask[w]) begin
                    data_mem[dbg_line_addr].words[w] <= dbg_req_i.data;
                end
            end
        end
        if (dbg_grant_o) begin
            line_rd_q <= data_mem[dbg_line_addr];
        end
        if (drain_rd_i) begin
            drain_line_o <= data_mem[drain_addr_i];
        end
    end

    // Remember which bank and word the pending read wants
    always_ff @(posedge clk) begin
        if (dbg_grant_o) begin
            rd_bank_q <= dbg_req_i.data_bank;
            rd_word_q <= dbg_req_i.word_sel;
        end
    end

    assign dbg_rdata_o = rd_bank_q ? line_rd_q.words[rd_word_q] : instr_rd_q;

endmodule

//--- drain_unit.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module drain_unit (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  accel_pkg::drain_job_t job_i,
    output logic                  busy_o,
    output logic                  rd_o,
    output accel_pkg::line_addr_t rd_addr_o,
    input  accel_pkg::data_line_u line_i,
    input  logic                  out_full_n_i,
    output logic                  out_push_o,
    output accel_pkg::half_t      out_data_o
);
    import accel_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_wait,
        st_shift
    } state_e;

    state_e     state;
    line_addr_t line_addr;
    logic [7:0] lines_left;
    logic [3:0] half_idx;
    data_line_u shift_q;

    // Busy covers the job cycle so the sequencer never misses it
    assign busy_o     = (state != st_idle) || job_i.valid;
    assign rd_o       = (state == st_fetch);
    assign rd_addr_o  = line_addr;
    assign out_push_o = (state == st_shift) && out_full_n_i;
    assign out_data_o = shift_q.halves[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (job_i.valid) begin
                        line_addr  <= job_i.start;
                        lines_left <= job_i.count;
                        state      <= st_fetch;
                    end
                end
                st_fetch: begin
                    state <= st_wait;
                end
                st_wait: begin
                    shift_q  <= line_i;
                    half_idx <= '0;
                    state    <= st_shift;
                end
                st_shift: begin
                    if (out_push_o) begin
                        shift_q.halves <= shift_q.halves >> `ACC_HALF_W;
                        half_idx       <= half_idx + 1'b1;
                        if (half_idx == 4'(`ACC_LINE_HALVES - 1)) begin
                            if (lines_left == '0) begin
                                state <= st_idle;
                            end else begin
                                lines_left <= lines_left - 1'b1;
                                line_addr  <= line_addr + 1'b1;
                                state      <= st_fetch;
                            end
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

//--- accelerator_top.sv
`timescale 1ns/1ps

module accelerator_top (
    input  logic                clk,
    input  logic                rst_n_i,
    input  accel_pkg::half_t    input_data_i,
    input  logic                input_vld_i,
    output logic                input_rdy_o,
    output accel_pkg::half_t    output_data_o,
    output logic                output_vld_o,
    input  logic                output_rdy_i,
    input  accel_pkg::wb_req_t  wb_i,
    output accel_pkg::word_t    wb_dat_o,
    output logic                wb_ack_o
);
    import accel_pkg::*;

    // ---------------------------------------------------------
    // Stream side
    // ---------------------------------------------------------

    half_t      in_dout;
    logic       in_empty_n;
    logic       in_pop;
    half_t      out_din;
    logic       out_push;
    logic       out_full_n;

    load_wr_t   load_wr;
    drain_job_t drain_job;
    logic       drain_busy;
    logic       drain_rd;
    line_addr_t drain_addr;
    data_line_u drain_line;

    // ---------------------------------------------------------
    // Debug side
    // ---------------------------------------------------------

    dbg_req_t   dbg_req;
    logic       dbg_grant;
    word_t      dbg_rdata;

    stream_fifo u_in_fifo (
        .clk       (clk         ),
        .rst_n_i   (rst_n_i     ),
        .din_i     (input_data_i),
        .push_i    (input_vld_i ),
        .full_n_o  (input_rdy_o ),
        .dout_o    (in_dout     ),
        .pop_i     (in_pop      ),
        .empty_n_o (in_empty_n  )
    );

    load_sequencer u_load_seq (
        .clk          (clk       ),
        .rst_n_i      (rst_n_i   ),
        .in_data_i    (in_dout   ),
        .in_empty_n_i (in_empty_n),
        .in_pop_o     (in_pop    ),
        .load_wr_o    (load_wr   ),
        .drain_job_o  (drain_job ),
        .drain_busy_i (drain_busy)
    );

    wb_debug_port u_wb_port (
        .clk         (clk      ),
        .rst_n_i     (rst_n_i  ),
        .wb_i        (wb_i     ),
        .wb_dat_o    (wb_dat_o ),
        .wb_ack_o    (wb_ack_o ),
        .dbg_req_o   (dbg_req  ),
        .dbg_grant_i (dbg_grant),
        .dbg_rdata_i (dbg_rdata)
    );

    bank_arbiter u_banks (
        .clk          (clk       ),
        .load_wr_i    (load_wr   ),
        .dbg_req_i    (dbg_req   ),
        .dbg_grant_o  (dbg_grant ),
        .dbg_rdata_o  (dbg_rdata ),
        .drain_rd_i   (drain_rd  ),
        .drain_addr_i (drain_addr),
        .drain_line_o (drain_line)
    );

    drain_unit u_drain (
        .clk          (clk       ),
        .rst_n_i      (rst_n_i   ),
        .job_i        (drain_job ),
        .busy_o       (drain_busy),
        .rd_o         (drain_rd  ),
        .rd_addr_o    (drain_addr),
        .line_i       (drain_line),
        .out_full_n_i (out_full_n),
        .out_push_o   (out_push  ),
        .out_data_o   (out_din   )
    );

    stream_fifo u_out_fifo (
        .clk       (clk          ),
        .rst_n_i   (rst_n_i      ),
        .din_i     (out_din      ),
        .push_i    (out_push     ),
        .full_n_o  (out_full_n   ),
        .dout_o    (output_data_o),
        .pop_i     (output_rdy_i ),
        .empty_n_o (output_vld_o )
    );

endmodule

//--- tb_accelerator.sv
`timescale 1ns/1ps
`include "accel_defs.svh"

module tb_accelerator;
    import accel_pkg::*;

    localparam int N_INSTR_LOADS = 4;
    localparam int INSTR_ITEMS   = 6;
    localparam int N_DATA_LOADS  = 3;
    localparam int DATA_ITEMS    = 3;
    localparam int N_PATCHES     = 2;
    localparam int BG_LINES      = 4;
    localparam int BG_BUS        = 8;
    localparam int SLOW_LINES    = 6;

    // Halfwords in and out plus bus cycles over all tests
    localparam int BUDGET_OPS = N_INSTR_LOADS * (2 + 3 * INSTR_ITEMS)
                              + N_DATA_LOADS * (4 + 32 * DATA_ITEMS)
                              + N_PATCHES * 20
                              + (4 + 32 * BG_LINES) + 2 * BG_BUS
                              + (4 + 32 * SLOW_LINES)
                              + 12;
    localparam int WATCHDOG_CYCLES = BUDGET_OPS * 40;

    logic    clk;
    logic    rst_n_i;
    half_t   input_data_i;
    logic    input_vld_i;
    logic    input_rdy_o;
    half_t   output_data_o;
    logic    output_vld_o;
    logic    output_rdy_i;
    wb_req_t wb_i;
    word_t   wb_dat_o;
    logic    wb_ack_o;

    word_t       instr_model [`ACC_INSTR_DEPTH];
    data_line_u  data_model  [`ACC_DATA_DEPTH];
    instr_addr_t instr_known [$];
    line_addr_t  data_starts [$];
    logic [31:0] lfsr_q = 32'h5cce_5b91;

    accelerator_top DUT (
        .clk           (clk          ),
        .rst_n_i       (rst_n_i      ),
        .input_data_i  (input_data_i ),
        .input_vld_i   (input_vld_i  ),
        .input_rdy_o   (input_rdy_o  ),
        .output_data_o (output_data_o),
        .output_vld_o  (output_vld_o ),
        .output_rdy_i  (output_rdy_i ),
        .wb_i          (wb_i         ),
        .wb_dat_o      (wb_dat_o     ),
        .wb_ack_o      (wb_ack_o     )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random source and failure handling
    // ------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_half(input string name, input half_t got, input half_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding",
                 WATCHDOG_CYCLES);
        abort_run();
    end

    // ------------------------------------------------------------
    // Input stream
    // ------------------------------------------------------------

    // Starts and ends on a falling edge
    task automatic send_half(input half_t h);
        input_data_i = h;
        input_vld_i  = 1'b1;
        while (!input_rdy_o) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic send_command(input cmd_kind_e op, input int items, input half_t addr);
        cmd_t c;
        c = '{kind: op, rsvd: 6'd0, count: 8'(items - 1)};
        send_half(half_t'(c));
        send_half(addr);
    endtask

    task automatic load_instr_words(input instr_addr_t start, input int items);
        word_t       w;
        instr_addr_t a;
        send_command(load_instr, items, half_t'(start));
        for (int i = 0; i < items; i++) begin
            w              = rand_bits(32);
            a              = start + instr_addr_t'(i);
            instr_model[a] = w;
            instr_known.push_back(a);
            // Low half first
            send_half(w[15:0]);
            send_half(w[31:16]);
        end
        input_vld_i = 1'b0;
    endtask

    task automatic load_data_lines(input line_addr_t start, input int items);
        data_line_u l;
        for (int i = 0; i < items; i++) begin
            for (int h = 0; h < `ACC_LINE_HALVES; h++) begin
                l.halves[h] = half_t'(rand_bits(`ACC_HALF_W));
            end
            data_model[start + line_addr_t'(i)] = l;
        end
        send_command(load_data, items, half_t'(start));
        for (int i = 0; i < items; i++) begin
            l = data_model[start + line_addr_t'(i)];
            for (int h = 0; h < `ACC_LINE_HALVES; h++) begin
                send_half(l.halves[h]);
            end
        end
        input_vld_i = 1'b0;
    endtask

    task automatic wait_for_writes();
        repeat (20) @(negedge clk);
    endtask

    // ------------------------------------------------------------
    // Drain with random back-pressure
    // ------------------------------------------------------------

    task automatic drain_and_check(input line_addr_t start, input int lines, input bit sparse);
        logic [31:0] r;
        half_t       exp;
        int          idx;
        send_command(drain, lines, half_t'(start));
        input_vld_i = 1'b0;
        idx         = 0;
        while (idx < lines * `ACC_LINE_HALVES) begin
            r            = rand_bits(sparse ? 2 : 1);
            output_rdy_i = sparse ? (r[1] & r[0]) : r[0];
            if (output_vld_o && output_rdy_i) begin
                exp = data_model[start + line_addr_t'(idx / `ACC_LINE_HALVES)]
                          .halves[idx % `ACC_LINE_HALVES];
                check_half("output_data_o", output_data_o, exp);
                idx++;
            end
            @(negedge clk);
        end
        output_rdy_i = 1'b0;
        repeat (8) @(negedge clk);
        if (output_vld_o) begin
            $display("An extra halfword appeared after a drain of %0d lines", lines);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------

    task automatic wb_transfer(input logic we, input logic [`ACC_WB_ADR_W-1:0] adr,
                               input word_t wdat, output word_t rdat);
        wb_i = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clk);
        while (!wb_ack_o) @(negedge clk);
        rdat = wb_dat_o;
        wb_i = '0;
        @(negedge clk);
    endtask

    task automatic write_instr(input instr_addr_t a, input word_t d);
        word_t unused;
        wb_transfer(1'b1, {3'b000, a}, d, unused);
        instr_model[a] = d;
    endtask

    task automatic read_instr(input instr_addr_t a);
        word_t got;
        wb_transfer(1'b0, {3'b000, a}, '0, got);
        check_word("wb_dat_o", got, instr_model[a]);
    endtask

    task automatic write_data_word(input line_addr_t line, input logic [2:0] k, input word_t d);
        word_t unused;
        wb_transfer(1'b1, {1'b1, line, k}, d, unused);
        // Word k lands on stream halfwords 2k and 2k+1, low half first
        data_model[line].halves[2 * k]     = d[15:0];
        data_model[line].halves[2 * k + 1] = d[31:16];
    endtask

    task automatic read_data_word(input line_addr_t line, input logic [2:0] k);
        word_t got;
        word_t exp;
        wb_transfer(1'b0, {1'b1, line, k}, '0, got);
        exp = {data_model[line].halves[2 * k + 1], data_model[line].halves[2 * k]};
        check_word("wb_dat_o", got, exp);
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------

    initial begin
        instr_addr_t bg_addr [BG_BUS];
        word_t       bg_data [BG_BUS];
        line_addr_t  start;
        instr_addr_t ia;
        logic [2:0]  k;
        int          n;

        input_data_i = '0;
        input_vld_i  = 1'b0;
        output_rdy_i = 1'b0;
        wb_i         = '0;
        rst_n_i      = 1'b0;
        repeat (2) @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);
        if (wb_ack_o || output_vld_o || !input_rdy_o) begin
            $display("Outputs are not in their reset state after reset");
            abort_run();
        end

        // Instruction loads read back over the bus
        for (int i = 0; i < N_INSTR_LOADS; i++) begin
            load_instr_words(instr_addr_t'(rand_bits(9)), INSTR_ITEMS);
        end
        wait_for_writes();
        foreach (instr_known[i]) begin
            read_instr(instr_known[i]);
        end

        // Data loads followed by one drain per load
        for (int i = 0; i < N_DATA_LOADS; i++) begin
            start = line_addr_t'(rand_bits(8));
            data_starts.push_back(start);
            load_data_lines(start, DATA_ITEMS);
        end
        for (int i = 0; i < N_DATA_LOADS; i++) begin
            drain_and_check(data_starts[i], DATA_ITEMS, 1'b0);
        end

        // Bus writes into single words of loaded lines
        wait_for_writes();
        for (int p = 0; p < N_PATCHES; p++) begin
            k = 3'(rand_bits(3));
            write_data_word(data_starts[p], k, rand_bits(32));
            read_data_word(data_starts[p], k);
            drain_and_check(data_starts[p], 1, 1'b0);
        end

        // Instruction bus traffic during a data load
        start = line_addr_t'(rand_bits(8));
        for (int i = 0; i < BG_BUS; i++) begin
            bg_addr[i] = instr_known[rand_bits(8) % instr_known.size()];
            bg_data[i] = rand_bits(32);
        end
        fork
            load_data_lines(start, BG_LINES);
            for (int i = 0; i < BG_BUS; i++) begin
                if (i % 2 == 0) begin
                    write_instr(bg_addr[i], bg_data[i]);
                end else begin
                    read_instr(bg_addr[i]);
                end
            end
        join
        wait_for_writes();
        for (int i = 0; i < BG_BUS; i++) begin
            read_instr(bg_addr[i]);
        end
        drain_and_check(start, BG_LINES, 1'b0);

        // Long drain under heavy back-pressure
        start = line_addr_t'(rand_bits(8));
        load_data_lines(start, SLOW_LINES);
        drain_and_check(start, SLOW_LINES, 1'b1);

        // Reserved command followed by a normal load
        n = int'(rand_bits(8)) + 1;
        send_command(reserved, n, half_t'(rand_bits(16)));
        ia = instr_addr_t'(rand_bits(9));
        load_instr_words(ia, 2);
        wait_for_writes();
        read_instr(ia);
        read_instr(ia + 1'b1);

        $display("Done: no errors");
        $finish;
    end

endmodule

//--- compile.f
+incdir+.
accel_pkg.sv
stream_fifo.sv
load_sequencer.sv
wb_debug_port.sv
bank_arbiter.sv
drain_unit.sv
accelerator_top.sv
tb_accelerator.sv
